//--- filelist.f
source/mem_bus_pkg.sv
source/cache_pkg.sv
source/tagged_memory.sv
source/mem_arbiter.sv
source/icache.sv
source/dcache.sv
source/mem_system.sv
verification/mem_checker.sv
verification/mem_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the memory system testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module mem_system_tb \
    -f filelist.f -o mem_system_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_system_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

//--- source/cache_pkg.sv
package cache_pkg;

    localparam int NUM_SETS   = 32;
    localparam int INDEX_BITS = 5;
    localparam int TAG_BITS   = 8;

    typedef struct packed {
        logic [63:0]         data;
        logic [TAG_BITS-1:0] tag;
        logic                valid;
    } cache_line_t;

    // a block seen by the data side as one double word,
    // and by the fetch side as two instructions, low word first.
    typedef union packed {
        logic [63:0]      dword;
        logic [1:0][31:0] words;
    } cache_block_t;

endpackage

//--- source/dcache.sv
`timescale 1ns/100ps

module dcache (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              load,
    input  logic                              store,
    input  logic [mem_bus_pkg::ADDR_BITS-1:0] address,
    input  logic [63:0]                       store_data,
    output logic                              load_valid,
    output logic [63:0]                       load_data,
    output logic                              store_done,
    output mem_bus_pkg::bus_request_t         bus_request,
    input  mem_bus_pkg::bus_response_t        bus_response
);

    typedef enum logic [1:0] {IDLE, LOAD_REQ, LOAD_WAIT, STORE_REQ} data_state_t;

    data_state_t                       state;
    cache_pkg::cache_line_t            lines [cache_pkg::NUM_SETS];
    logic [cache_pkg::INDEX_BITS-1:0]  index;
    logic [cache_pkg::TAG_BITS-1:0]    tag;
    logic [mem_bus_pkg::ADDR_BITS-1:0] req_address;
    logic [63:0]                       req_data;
    logic [cache_pkg::INDEX_BITS-1:0]  req_index;
    mem_bus_pkg::mem_tag_t             miss_tag;
    logic                              hit;
    logic                              accepted;
    logic                              fill_done;
    logic                              hit_valid;
    logic [63:0]                       hit_data;

    assign index     = address[3 +: cache_pkg::INDEX_BITS];
    assign tag       = address[mem_bus_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
    assign req_index = req_address[3 +: cache_pkg::INDEX_BITS];

    assign hit       = lines[index].valid && (lines[index].tag == tag);
    assign accepted  = bus_response.response != '0;
    assign fill_done = (state == LOAD_WAIT) && (bus_response.tag == miss_tag);

    assign load_valid = hit_valid | fill_done;
    assign load_data  = fill_done ? bus_response.data : hit_data;
    assign store_done = (state == STORE_REQ) && accepted;  // write-through ends at acceptance.

    always_comb begin
        bus_request.address = req_address[mem_bus_pkg::ADDR_BITS-1:3];
        bus_request.data    = req_data;
        case (state)
            LOAD_REQ:  bus_request.command = mem_bus_pkg::BUS_LOAD;
            STORE_REQ: bus_request.command = mem_bus_pkg::BUS_STORE;
            default:   bus_request.command = mem_bus_pkg::BUS_NONE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            hit_valid <= 1'b0;
            for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else begin
            hit_valid <= load && hit;
            case (state)
                IDLE: begin
                    if (load && !hit) begin
                        state <= LOAD_REQ;
                    end else if (store) begin
                        state <= STORE_REQ;
                        if (hit) begin
                            lines[index].data <= store_data;  // a store miss leaves the line alone.
                        end
                    end
                end
                LOAD_REQ: begin
                    if (accepted) begin
                        state <= LOAD_WAIT;
                    end
                end
                LOAD_WAIT: begin
                    if (fill_done) begin
                        state <= IDLE;
                        lines[req_index] <= '{data:  bus_response.data,
                                              tag:   req_address[mem_bus_pkg::ADDR_BITS-1 -:
                                                         cache_pkg::TAG_BITS],
                                              valid: 1'b1};
                    end
                end
                STORE_REQ: begin
                    if (accepted) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (load || store) begin
            req_address <= address;
        end
        if (store) begin
            req_data <= store_data;
        end
        if (load) begin
            hit_data <= lines[index].data;
        end
        if (state == LOAD_REQ && accepted) begin
            miss_tag <= bus_response.response;
        end
    end

endmodule

//--- source/icache.sv
`timescale 1ns/100ps

module icache (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              fetch,
    input  logic [mem_bus_pkg::ADDR_BITS-1:0] pc,
    output logic                              fetch_valid,
    output logic [31:0]                       instruction,
    output mem_bus_pkg::bus_request_t         bus_request,
    input  mem_bus_pkg::bus_response_t        bus_response
);

    typedef enum logic [1:0] {IDLE, REQUEST, WAIT_DATA} fill_state_t;

    fill_state_t                       state;
    cache_pkg::cache_line_t            lines [cache_pkg::NUM_SETS];
    logic [cache_pkg::INDEX_BITS-1:0]  index;
    logic [cache_pkg::TAG_BITS-1:0]    tag;
    logic [mem_bus_pkg::ADDR_BITS-1:0] miss_pc;
    logic [cache_pkg::INDEX_BITS-1:0]  miss_index;
    mem_bus_pkg::mem_tag_t             miss_tag;
    cache_pkg::cache_block_t           hit_block;
    cache_pkg::cache_block_t           fill_block;
    logic                              hit;
    logic                              accepted;
    logic                              fill_done;
    logic                              hit_valid;
    logic [31:0]                       hit_instruction;

    assign index      = pc[3 +: cache_pkg::INDEX_BITS];
    assign tag        = pc[mem_bus_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
    assign miss_index = miss_pc[3 +: cache_pkg::INDEX_BITS];

    assign hit       = lines[index].valid && (lines[index].tag == tag);
    assign accepted  = bus_response.response != '0;
    assign fill_done = (state == WAIT_DATA) && (bus_response.tag == miss_tag);

    assign hit_block.dword  = lines[index].data;
    assign fill_block.dword = bus_response.data;

    // a fill answers in the cycle its data shows up; a hit answers one cycle late.
    assign fetch_valid = hit_valid | fill_done;
    assign instruction = fill_done ? fill_block.words[miss_pc[2]] : hit_instruction;

    always_comb begin
        bus_request.command = (state == REQUEST) ? mem_bus_pkg::BUS_LOAD : mem_bus_pkg::BUS_NONE;
        bus_request.address = miss_pc[mem_bus_pkg::ADDR_BITS-1:3];
        bus_request.data    = '0;  // fetches never write.
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            hit_valid <= 1'b0;
            for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else begin
            hit_valid <= fetch && hit;
            case (state)
                IDLE: begin
                    if (fetch && !hit) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (accepted) begin
                        state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (fill_done) begin
                        state <= IDLE;
                        lines[miss_index] <= '{data:  bus_response.data,
                                               tag:   miss_pc[mem_bus_pkg::ADDR_BITS-1 -:
                                                          cache_pkg::TAG_BITS],
                                               valid: 1'b1};
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch) begin
            miss_pc         <= pc;
            hit_instruction <= hit_block.words[pc[2]];
        end
        if (state == REQUEST && accepted) begin
            miss_tag <= bus_response.response;
        end
    end

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                       clock,
    input  logic                       reset,
    input  mem_bus_pkg::bus_request_t  imem_request,
    input  mem_bus_pkg::bus_request_t  dmem_request,
    output mem_bus_pkg::bus_response_t imem_response,
    output mem_bus_pkg::bus_response_t dmem_response,
    output mem_bus_pkg::bus_request_t  mem_request,
    input  mem_bus_pkg::bus_response_t mem_response
);

    typedef enum logic [1:0] {IDLE, IMEM, DMEM} owner_t;

    owner_t state;
    owner_t owner;
    logic   imem_busy;
    logic   dmem_busy;
    logic   owner_is_data [1:15];  // one entry per live tag.
    logic   tag_is_data;
    logic   tag_is_inst;

    assign imem_busy = imem_request.command != mem_bus_pkg::BUS_NONE;
    assign dmem_busy = dmem_request.command != mem_bus_pkg::BUS_NONE;

    // the owner holds on while it has work, otherwise the bus moves over or goes idle.
    always_comb begin
        case (state)
            IMEM: begin
                owner = imem_busy ? IMEM : (dmem_busy ? DMEM : IDLE);
            end
            DMEM: begin
                owner = dmem_busy ? DMEM : (imem_busy ? IMEM : IDLE);
            end
            default: begin
                owner = dmem_busy ? DMEM : (imem_busy ? IMEM : IDLE);  // data goes first.
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= owner;
        end
    end

    always_comb begin
        case (owner)
            IMEM:    mem_request = imem_request;
            DMEM:    mem_request = dmem_request;
            default: mem_request = '{command: mem_bus_pkg::BUS_NONE, address: '0, data: '0};
        endcase
    end

    always_ff @(posedge clock) begin
        if (mem_request.command == mem_bus_pkg::BUS_LOAD && mem_response.response != '0) begin
            owner_is_data[mem_response.response] <= (owner == DMEM);
        end
    end

    assign tag_is_data = (mem_response.tag != '0) && owner_is_data[mem_response.tag];
    assign tag_is_inst = (mem_response.tag != '0) && !owner_is_data[mem_response.tag];

    // the side that lost this cycle sees a zero accept tag and keeps its command up.
    always_comb begin
        imem_response.response = (owner == IMEM) ? mem_response.response : '0;
        imem_response.tag      = tag_is_inst ? mem_response.tag : '0;
        imem_response.data     = mem_response.data;
        dmem_response.response = (owner == DMEM) ? mem_response.response : '0;
        dmem_response.tag      = tag_is_data ? mem_response.tag : '0;
        dmem_response.data     = mem_response.data;
    end

endmodule

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int ADDR_BITS   = 16;
    localparam int MEM_LATENCY = 4;  // cycles from acceptance to load data.

    typedef enum logic [1:0] {
        BUS_NONE,
        BUS_LOAD,
        BUS_STORE
    } bus_command_t;

    // zero never names a live transaction, so it also means rejected.
    typedef logic [3:0] mem_tag_t;

    typedef logic [12:0] block_addr_t;  // one address per 64-bit block.

    typedef struct packed {
        bus_command_t command;
        block_addr_t  address;
        logic [63:0]  data;
    } bus_request_t;

    // response is the accept tag for this cycle's command.
    // tag marks the cycle in which load data for that tag is on the bus.
    typedef struct packed {
        mem_tag_t    response;
        mem_tag_t    tag;
        logic [63:0] data;
    } bus_response_t;

endpackage

//--- source/mem_system.sv
`timescale 1ns/100ps

module mem_system (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              fetch,
    input  logic [mem_bus_pkg::ADDR_BITS-1:0] pc,
    output logic                              fetch_valid,
    output logic [31:0]                       instruction,
    input  logic                              load,
    input  logic                              store,
    input  logic [mem_bus_pkg::ADDR_BITS-1:0] address,
    input  logic [63:0]                       store_data,
    output logic                              load_valid,
    output logic [63:0]                       load_data,
    output logic                              store_done
);

    mem_bus_pkg::bus_request_t  imem_request;
    mem_bus_pkg::bus_request_t  dmem_request;
    mem_bus_pkg::bus_request_t  mem_request;
    mem_bus_pkg::bus_response_t imem_response;
    mem_bus_pkg::bus_response_t dmem_response;
    mem_bus_pkg::bus_response_t mem_response;

    icache icache_0 (
        .clock(clock), .reset(reset),
        .fetch(fetch), .pc(pc),
        .fetch_valid(fetch_valid), .instruction(instruction),
        .bus_request(imem_request), .bus_response(imem_response)
    );

    dcache dcache_0 (
        .clock(clock), .reset(reset),
        .load(load), .store(store), .address(address), .store_data(store_data),
        .load_valid(load_valid), .load_data(load_data), .store_done(store_done),
        .bus_request(dmem_request), .bus_response(dmem_response)
    );

    mem_arbiter arbiter_0 (
        .clock(clock), .reset(reset),
        .imem_request(imem_request), .dmem_request(dmem_request),
        .imem_response(imem_response), .dmem_response(dmem_response),
        .mem_request(mem_request), .mem_response(mem_response)
    );

    tagged_memory memory_0 (
        .clock(clock), .reset(reset),
        .request(mem_request), .response(mem_response)
    );

endmodule

//--- source/tagged_memory.sv
`timescale 1ns/100ps

module tagged_memory (
    input  logic                       clock,
    input  logic                       reset,
    input  mem_bus_pkg::bus_request_t  request,
    output mem_bus_pkg::bus_response_t response
);

    logic [63:0] blocks [0:(1 << $bits(mem_bus_pkg::block_addr_t)) - 1];

    mem_bus_pkg::mem_tag_t next_tag;
    mem_bus_pkg::mem_tag_t pipe_tag [mem_bus_pkg::MEM_LATENCY];
    logic [63:0]           pipe_data [mem_bus_pkg::MEM_LATENCY];
    logic                  accepted;
    logic                  is_load;
    logic                  is_store;

    assign accepted = request.command != mem_bus_pkg::BUS_NONE;  // every command is taken.
    assign is_load  = request.command == mem_bus_pkg::BUS_LOAD;
    assign is_store = request.command == mem_bus_pkg::BUS_STORE;

    always_comb begin
        response.response = accepted ? next_tag : '0;
        response.tag      = pipe_tag[mem_bus_pkg::MEM_LATENCY-1];
        response.data     = pipe_data[mem_bus_pkg::MEM_LATENCY-1];
    end

    // tags run 1 to 15 and skip zero on the wrap.
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
        end else if (accepted) begin
            next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_bus_pkg::MEM_LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= is_load ? next_tag : '0;  // stores send nothing back.
            for (int i = 1; i < mem_bus_pkg::MEM_LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    // the array is read at acceptance, so a load sees every store accepted before it.
    always_ff @(posedge clock) begin
        pipe_data[0] <= blocks[request.address];
        for (int i = 1; i < mem_bus_pkg::MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
        if (is_store) begin
            blocks[request.address] <= request.data;
        end
    end

endmodule

//--- verification/mem_checker.sv
`timescale 1ns/100ps

module mem_checker (
    input  logic            clock,
    input  logic            reset,
    input  logic            fetch,
    input  logic            load,
    input  logic            store,
    input  logic            fetch_valid,
    input  logic [31:0]     instruction,
    input  logic            load_valid,
    input  logic [63:0]     load_data,
    input  logic            store_done,
    input  logic            fetch_hit,
    input  logic            load_hit,
    input  logic [31:0]     expected_instruction,
    input  logic [63:0]     expected_data,
    input  logic [8*16-1:0] test_name,
    output int              error_count,
    output int              check_count
);

    logic fetch_pending;
    logic load_pending;
    logic store_pending;
    int   fetch_age;   // edges seen since the fetch strobe.
    int   data_age;

    // a hit answers exactly one cycle after its strobe, a miss takes longer.
    task automatic check_answer(input string what, input logic [63:0] expected,
                                input logic [63:0] actual, input logic hit, input int age);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0s %0s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
        if (hit && age != 1) begin
            error_count++;
            $display("%0s: the %0s hit answered %0d cycles after its strobe instead of one",
                     test_name, what, age);
        end else if (!hit && age == 1) begin
            error_count++;
            $display("%0s: the %0s answered in one cycle although its line was not cached",
                     test_name, what);
        end
    endtask

    task automatic report_stray(input string what);
        error_count++;
        $display("%0s went active with no request waiting for it", what);
    endtask

    always @(posedge clock) begin
        if (reset) begin
            fetch_pending <= 1'b0;
            load_pending  <= 1'b0;
            store_pending <= 1'b0;
        end else begin
            if (fetch_valid !== 1'b0) begin
                if (fetch_pending) begin
                    check_answer("fetch", {32'h0, expected_instruction}, {32'h0, instruction},
                                 fetch_hit, fetch_age);
                end else begin
                    report_stray("fetch_valid");
                end
                fetch_pending <= 1'b0;
            end
            if (load_valid !== 1'b0) begin
                if (load_pending) begin
                    check_answer("load", expected_data, load_data, load_hit, data_age);
                end else begin
                    report_stray("load_valid");
                end
                load_pending <= 1'b0;
            end
            if (store_done !== 1'b0) begin
                if (store_pending) begin
                    check_count++;
                end else begin
                    report_stray("store_done");
                end
                store_pending <= 1'b0;
            end
            fetch_age <= fetch ? 1 : fetch_age + 1;
            data_age  <= (load || store) ? 1 : data_age + 1;
            if (fetch) fetch_pending <= 1'b1;
            if (load) load_pending <= 1'b1;
            if (store) store_pending <= 1'b1;
        end
    end

endmodule

//--- verification/mem_patterns.txt
# op address value gap; S stores the value, F and L expect it, gap is idle cycles after the answer.
# B fetches and loads together; address is {pc, load address}, value is {instruction, load data}.
S 0040 1122334455667788 2
L 0040 1122334455667788 1
L 0040 1122334455667788 1
S 0200 a1b2c3d4e5f60718 2
F 0200 e5f60718 1
F 0204 a1b2c3d4 1
S 0308 0f0e0d0c0b0a0908 1
S 0410 1234567890abcdef 1
B 03080410 0b0a09081234567890abcdef 2
B 02040040 a1b2c3d41122334455667788 1
S 1a28 00000000cafe0001 1
S 2b28 00000000cafe0002 1
L 1a28 00000000cafe0001 1
L 2b28 00000000cafe0002 1
L 1a28 00000000cafe0001 1
S 1a28 5555aaaa5555aaaa 1
L 1a28 5555aaaa5555aaaa 0

//--- verification/mem_system_tb.sv
`timescale 1ns/100ps

module mem_system_tb;

    logic                              clock;
    logic                              reset;
    logic                              fetch;
    logic [mem_bus_pkg::ADDR_BITS-1:0] pc;
    logic                              fetch_valid;
    logic [31:0]                       instruction;
    logic                              load;
    logic                              store;
    logic [mem_bus_pkg::ADDR_BITS-1:0] address;
    logic [63:0]                       store_data;
    logic                              load_valid;
    logic [63:0]                       load_data;
    logic                              store_done;
    logic                              fetch_hit;
    logic                              load_hit;
    logic [31:0]                       expected_instruction;
    logic [63:0]                       expected_data;
    logic [8*16-1:0]                   test_name;
    int                                error_count;
    int                                check_count;
    int                                cycle_limit;
    int                                cycle_count = 0;

    // one entry per pattern; B packs {pc, load address} and {instruction, load data}.
    logic [7:0]  op_queue [$];
    logic [31:0] address_queue [$];
    logic [95:0] value_queue [$];
    int          gap_queue [$];

    // valid bit over tag for every set, as the cache rules leave it.
    logic [cache_pkg::TAG_BITS:0] icache_sets [cache_pkg::NUM_SETS];
    logic [cache_pkg::TAG_BITS:0] dcache_sets [cache_pkg::NUM_SETS];

    mem_system dut (
        .clock(clock), .reset(reset),
        .fetch(fetch), .pc(pc), .fetch_valid(fetch_valid), .instruction(instruction),
        .load(load), .store(store), .address(address), .store_data(store_data),
        .load_valid(load_valid), .load_data(load_data), .store_done(store_done)
    );

    mem_checker scoreboard (
        .clock(clock), .reset(reset), .fetch(fetch), .load(load), .store(store),
        .fetch_valid(fetch_valid), .instruction(instruction),
        .load_valid(load_valid), .load_data(load_data), .store_done(store_done),
        .fetch_hit(fetch_hit), .load_hit(load_hit),
        .expected_instruction(expected_instruction), .expected_data(expected_data),
        .test_name(test_name), .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the patterns did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [cache_pkg::TAG_BITS:0] set_entry(
        input logic [mem_bus_pkg::ADDR_BITS-1:0] addr
    );
        return {1'b1, addr[mem_bus_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS]};
    endfunction

    function automatic bit read_patterns();
        int               fd;
        int               code;
        logic [7:0]       op;
        logic [8*128-1:0] comment;
        logic [31:0]      addr;
        logic [95:0]      value;
        int               gap;
        fd = $fopen("verification/mem_patterns.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code == 1 && op == "#") begin
                code = $fgets(comment, fd);  // skip the rest of a comment line.
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %h %d", addr, value, gap);
                op_queue.push_back(op);
                address_queue.push_back(addr);
                value_queue.push_back(value);
                gap_queue.push_back(gap);
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    task automatic run_pattern(input int n);
        logic [7:0]                        op;
        logic [mem_bus_pkg::ADDR_BITS-1:0] fetch_pc;
        logic [mem_bus_pkg::ADDR_BITS-1:0] data_address;
        logic [cache_pkg::INDEX_BITS-1:0]  fetch_index;
        logic [cache_pkg::INDEX_BITS-1:0]  data_index;
        logic [8*16-1:0]                   name;
        logic                              want_fetch;
        logic                              want_load;
        logic                              got_fetch;
        logic                              got_data;
        op           = op_queue[n];
        want_fetch   = (op == "F") || (op == "B");
        want_load    = (op == "L") || (op == "B");
        fetch_pc     = (op == "B") ? address_queue[n][31:16] : address_queue[n][15:0];
        data_address = address_queue[n][15:0];
        fetch_index  = fetch_pc[3 +: cache_pkg::INDEX_BITS];
        data_index   = data_address[3 +: cache_pkg::INDEX_BITS];
        $sformat(name, "pattern%0d_%c", n + 1, op);
        @(posedge clock);
        fetch                <= want_fetch;
        load                 <= want_load;
        store                <= (op == "S");
        pc                   <= fetch_pc;
        address              <= data_address;
        store_data           <= value_queue[n][63:0];
        expected_instruction <= (op == "B") ? value_queue[n][95:64] : value_queue[n][31:0];
        expected_data        <= value_queue[n][63:0];
        test_name            <= name;
        fetch_hit            <= icache_sets[fetch_index] == set_entry(fetch_pc);
        load_hit             <= dcache_sets[data_index] == set_entry(data_address);
        if (want_fetch) icache_sets[fetch_index] = set_entry(fetch_pc);
        if (want_load) dcache_sets[data_index] = set_entry(data_address);  // stores never allocate.
        @(posedge clock);
        fetch     <= 1'b0;
        load      <= 1'b0;
        store     <= 1'b0;
        got_fetch = !want_fetch;
        got_data  = (op == "F");
        while (!(got_fetch && got_data)) begin
            @(posedge clock);
            got_fetch = got_fetch || fetch_valid;
            got_data  = got_data || load_valid || store_done;
        end
        repeat (gap_queue[n]) @(posedge clock);
    endtask

    initial begin
        int total_gap;
        reset                = 1'b1;
        fetch                = 1'b0;
        load                 = 1'b0;
        store                = 1'b0;
        pc                   = '0;
        address              = '0;
        store_data           = '0;
        fetch_hit            = 1'b0;
        load_hit             = 1'b0;
        expected_instruction = '0;
        expected_data        = '0;
        test_name            = '0;
        total_gap            = 0;
        for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
            icache_sets[i] = '0;
            dcache_sets[i] = '0;
        end
        if (!read_patterns()) begin
            $display("the pattern file verification/mem_patterns.txt could not be opened");
            $display("Verification failed");
            $finish;
        end else begin
            foreach (gap_queue[i]) begin
                total_gap += gap_queue[i];
            end
            cycle_limit = total_gap + 30 * op_queue.size() + 100;
            repeat (16) @(posedge clock);
            reset <= 1'b0;
            foreach (op_queue[i]) begin
                run_pattern(i);
            end
            repeat (2) @(posedge clock);
            $display("%0d checks done, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule
